//--- logic/battle_cfg.svh
`ifndef BATTLE_CFG_SVH
`define BATTLE_CFG_SVH

// word width of hit points, speeds and skill damages
`define BATTLE_HP_W 8

// timer lengths in clock cycles
// short values keep simulation fast, hardware builds raise them
`define BATTLE_ANIM_TICKS 8
`define BATTLE_HP_TICKS 4
`define BATTLE_END_TICKS 16

`endif

//--- logic/battle_pkg.sv
`include "battle_cfg.svh"

package battle_pkg;

    // one hit-point, speed or damage value
    typedef logic [`BATTLE_HP_W-1:0] hp_t;

    // stats of one fighter
    typedef struct packed {
        hp_t hp;
        hp_t speed;
        hp_t dmg1;
        hp_t dmg2;
        hp_t dmg3;
    } fighter_t;

    // raw key levels
    typedef struct packed {
        logic up;
        logic down;
        logic left;
        logic right;
        logic confirm;
    } buttons_t;

    typedef enum logic [2:0] {
        menu,
        choosing_skill,
        attack_p1,
        attack_p2,
        drain_p1,
        drain_p2,
        p1_win,
        p2_win
    } fight_state_e;

    // skill grid: opt1 opt2 on top, opt3 opt4 below, opt4 is back
    // menu: opt1 is fight, opt2 is run
    typedef enum logic [1:0] {
        opt1,
        opt2,
        opt3,
        opt4
    } option_e;

    typedef enum logic [1:0] {
        mode_idle,
        mode_menu,
        mode_skill
    } cursor_mode_e;

endpackage

//--- logic/tick_timer.sv
`timescale 1ns/1ps

module tick_timer #(
    parameter int ticks = 4
) (
    input  logic clk,
    input  logic reset,
    input  logic run,
    output logic tick
);

    localparam int cnt_w = (ticks > 1) ? $clog2(ticks) : 1;
    localparam logic [cnt_w-1:0] last = cnt_w'(ticks - 1);

    logic [cnt_w-1:0] count;

    // count clears whenever run drops, so each run starts a full period
    always_ff @(posedge clk) begin
        if (reset || !run) begin
            count <= '0;
        end else if (count == last) begin
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

    assign tick = run && (count == last);

endmodule

//--- logic/option_cursor.sv
`timescale 1ns/1ps

module option_cursor (
    input  logic                     clk,
    input  logic                     reset,
    input  battle_pkg::buttons_t     keys,
    input  battle_pkg::cursor_mode_e mode,
    input  logic                     home,
    output battle_pkg::option_e      option,
    output logic                     pick
);

    import battle_pkg::*;

    logic lone;
    logic row;
    logic col;
    logic row_nx;
    logic col_nx;

    // a press only counts when exactly one key is down
    assign lone = $onehot(keys);
    assign pick = lone && keys.confirm && (mode != mode_idle);

    // option code is {row, col} of the 2x2 grid
    assign row = option[1];
    assign col = option[0];

    ////////////////////////////////////////////////////////////////////
    // cursor moves
    ////////////////////////////////////////////////////////////////////

    always_comb begin
        row_nx = row;
        col_nx = col;
        if (lone) begin
            case (mode)
                mode_menu: begin
                    // menu is a single row of two entries
                    row_nx = 1'b0;
                    if (keys.right) begin
                        col_nx = 1'b1;
                    end
                    if (keys.left) begin
                        col_nx = 1'b0;
                    end
                end
                mode_skill: begin
                    // moves past an edge just saturate
                    if (keys.right) begin
                        col_nx = 1'b1;
                    end
                    if (keys.left) begin
                        col_nx = 1'b0;
                    end
                    if (keys.down) begin
                        row_nx = 1'b1;
                    end
                    if (keys.up) begin
                        row_nx = 1'b0;
                    end
                end
                default: begin
                    row_nx = row;
                    col_nx = col;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset || home) begin
            option <= opt1;
        end else begin
            option <= option_e'({row_nx, col_nx});
        end
    end

endmodule

//--- logic/hp_drain.sv
`timescale 1ns/1ps
`include "battle_cfg.svh"

module hp_drain (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 load,
    input  battle_pkg::fighter_t p1,
    input  battle_pkg::fighter_t p2,
    input  logic                 strike,
    input  battle_pkg::option_e  skill,
    input  logic [1:0]           drain,
    output battle_pkg::hp_t      p1_hp,
    output battle_pkg::hp_t      p2_hp,
    output logic                 p1_done,
    output logic                 p2_done,
    output logic                 p1_out,
    output logic                 p2_out
);

    import battle_pkg::*;

    hp_t  p1_tgt;
    hp_t  p2_tgt;
    logic hp_tick;

    // damage of the chosen skill, back deals none
    function automatic hp_t skill_dmg(fighter_t f, option_e s);
        case (s)
            opt1:    return f.dmg1;
            opt2:    return f.dmg2;
            opt3:    return f.dmg3;
            default: return '0;
        endcase
    endfunction

    // floor at zero
    function automatic hp_t sat_sub(hp_t a, hp_t b);
        return (a > b) ? hp_t'(a - b) : '0;
    endfunction

    // drain[0] drains p1, drain[1] drains p2
    tick_timer #(.ticks(`BATTLE_HP_TICKS)) hp_timer (
        .clk   (clk),
        .reset (reset),
        .run   (|drain),
        .tick  (hp_tick)
    );

    assign p1_done = (p1_hp == p1_tgt);
    assign p2_done = (p2_hp == p2_tgt);
    assign p1_out  = (p1_hp == '0);
    assign p2_out  = (p2_hp == '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            p1_hp  <= '0;
            p2_hp  <= '0;
            p1_tgt <= '0;
            p2_tgt <= '0;
        end else if (load) begin
            p1_hp  <= p1.hp;
            p2_hp  <= p2.hp;
            p1_tgt <= p1.hp;
            p2_tgt <= p2.hp;
        end else begin
            // each side takes the opponent's damage for the same skill
            if (strike) begin
                p1_tgt <= sat_sub(p1_hp, skill_dmg(p2, skill));
                p2_tgt <= sat_sub(p2_hp, skill_dmg(p1, skill));
            end
            if (drain[0] && hp_tick && !p1_done && !p1_out) begin
                p1_hp <= p1_hp - 1'b1;
            end
            if (drain[1] && hp_tick && !p2_done && !p2_out) begin
                p2_hp <= p2_hp - 1'b1;
            end
        end
    end

endmodule

//--- logic/battle_fsm.sv
`timescale 1ns/1ps
`include "battle_cfg.svh"

module battle_fsm (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     load,
    input  battle_pkg::hp_t          p1_speed,
    input  battle_pkg::hp_t          p2_speed,
    input  logic                     pick,
    input  battle_pkg::option_e      option,
    input  logic                     p1_done,
    input  logic                     p2_done,
    input  logic                     p1_out,
    input  logic                     p2_out,
    output battle_pkg::fight_state_e state,
    output battle_pkg::cursor_mode_e mode,
    output logic                     home,
    output logic                     strike,
    output battle_pkg::option_e      skill,
    output logic [1:0]               drain,
    output logic                     end_scene
);

    import battle_pkg::*;

    fight_state_e state_nx;
    logic         p1_faster;
    logic         p1_first;
    logic         anim_run;
    logic         anim_tick;
    logic         win;
    logic         end_done;
    logic         end_tick;

    // ties go to p1
    assign p1_faster = (p1_speed >= p2_speed);

    assign anim_run = (state == attack_p1) || (state == attack_p2);
    assign win      = (state == p1_win) || (state == p2_win);

    tick_timer #(.ticks(`BATTLE_ANIM_TICKS)) anim_timer (
        .clk   (clk),
        .reset (reset),
        .run   (anim_run),
        .tick  (anim_tick)
    );

    // stops after one period so the ending strobe fires once
    tick_timer #(.ticks(`BATTLE_END_TICKS)) end_timer (
        .clk   (clk),
        .reset (reset),
        .run   (win && !end_done),
        .tick  (end_tick)
    );

    ////////////////////////////////////////////////////////////////////
    // next state
    ////////////////////////////////////////////////////////////////////

    always_comb begin
        state_nx = state;
        if (load) begin
            state_nx = menu;
        end else begin
            case (state)
                menu: begin
                    if (pick && option == opt1) begin
                        state_nx = choosing_skill;
                    end else if (pick && option == opt2) begin
                        state_nx = p2_win;
                    end
                end
                choosing_skill: begin
                    if (pick && option == opt4) begin
                        state_nx = menu;
                    end else if (pick) begin
                        state_nx = p1_faster ? attack_p1 : attack_p2;
                    end
                end
                attack_p1: begin
                    if (anim_tick) begin
                        state_nx = drain_p2;
                    end
                end
                attack_p2: begin
                    if (anim_tick) begin
                        state_nx = drain_p1;
                    end
                end
                drain_p1: begin
                    // p1 first means p1 already attacked, round is over
                    if (p1_out) begin
                        state_nx = p2_win;
                    end else if (p1_done) begin
                        state_nx = p1_first ? menu : attack_p1;
                    end
                end
                drain_p2: begin
                    if (p2_out) begin
                        state_nx = p1_win;
                    end else if (p2_done) begin
                        state_nx = p1_first ? attack_p2 : menu;
                    end
                end
                default: begin
                    // win states hold until load
                    state_nx = state;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= menu;
            p1_first <= 1'b1;
        end else begin
            state <= state_nx;
            if (strike) begin
                p1_first <= p1_faster;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////
    // outputs to cursor and hp unit
    ////////////////////////////////////////////////////////////////////

    always_comb begin
        case (state)
            menu:           mode = mode_menu;
            choosing_skill: mode = mode_skill;
            default:        mode = mode_idle;
        endcase
    end

    // cursor goes home on entry to a menu, and on every load
    assign home = (load || state_nx != state) &&
                  (state_nx == menu || state_nx == choosing_skill);

    assign strike = (state == choosing_skill) && pick && (option != opt4);
    assign skill  = option;
    assign drain  = {state == drain_p2, state == drain_p1};

    // ending strobe, one cycle after the end timer expires
    always_ff @(posedge clk) begin
        if (reset || load) begin
            end_done  <= 1'b0;
            end_scene <= 1'b0;
        end else begin
            end_scene <= end_tick;
            if (end_tick) begin
                end_done <= 1'b1;
            end
        end
    end

endmodule

//--- logic/battle_top.sv
`timescale 1ns/1ps

module battle_top (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     load,
    input  battle_pkg::fighter_t     p1,
    input  battle_pkg::fighter_t     p2,
    input  battle_pkg::buttons_t     keys,
    output battle_pkg::hp_t          p1_hp,
    output battle_pkg::hp_t          p2_hp,
    output battle_pkg::fight_state_e fight_state,
    output battle_pkg::option_e      option,
    output logic                     end_scene
);

    import battle_pkg::*;

    logic         pick;
    logic         home;
    logic         strike;
    cursor_mode_e mode;
    option_e      skill;
    logic [1:0]   drain;
    logic         p1_done;
    logic         p2_done;
    logic         p1_out;
    logic         p2_out;

    option_cursor cursor0 (
        .clk    (clk),
        .reset  (reset),
        .keys   (keys),
        .mode   (mode),
        .home   (home),
        .option (option),
        .pick   (pick)
    );

    battle_fsm fsm0 (
        .clk       (clk),
        .reset     (reset),
        .load      (load),
        .p1_speed  (p1.speed),
        .p2_speed  (p2.speed),
        .pick      (pick),
        .option    (option),
        .p1_done   (p1_done),
        .p2_done   (p2_done),
        .p1_out    (p1_out),
        .p2_out    (p2_out),
        .state     (fight_state),
        .mode      (mode),
        .home      (home),
        .strike    (strike),
        .skill     (skill),
        .drain     (drain),
        .end_scene (end_scene)
    );

    hp_drain hp0 (
        .clk     (clk),
        .reset   (reset),
        .load    (load),
        .p1      (p1),
        .p2      (p2),
        .strike  (strike),
        .skill   (skill),
        .drain   (drain),
        .p1_hp   (p1_hp),
        .p2_hp   (p2_hp),
        .p1_done (p1_done),
        .p2_done (p2_done),
        .p1_out  (p1_out),
        .p2_out  (p2_out)
    );

endmodule

//--- tests/battle_tb.sv
`timescale 1ns/1ps
`include "battle_cfg.svh"

module battle_tb;

    import battle_pkg::*;

    localparam int timeout_cycles = 1000;

    localparam buttons_t key_up      = 5'b10000;
    localparam buttons_t key_down    = 5'b01000;
    localparam buttons_t key_left    = 5'b00100;
    localparam buttons_t key_right   = 5'b00010;
    localparam buttons_t key_confirm = 5'b00001;

    logic         clk;
    logic         reset;
    logic         load;
    fighter_t     p1;
    fighter_t     p2;
    buttons_t     keys;
    hp_t          p1_hp;
    hp_t          p2_hp;
    fight_state_e fight_state;
    option_e      option;
    logic         end_scene;

    integer  seed;
    hp_t     exp_p1;
    hp_t     exp_p2;
    option_e exp_opt;
    event    round_done;

    battle_top dut0 (
        .clk         (clk),
        .reset       (reset),
        .load        (load),
        .p1          (p1),
        .p2          (p2),
        .keys        (keys),
        .p1_hp       (p1_hp),
        .p2_hp       (p2_hp),
        .fight_state (fight_state),
        .option      (option),
        .end_scene   (end_scene)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////////////////////////

    // hit points left after a hit, floored at zero
    function automatic hp_t expect_hp(hp_t hp, hp_t dmg);
        if (hp > dmg) begin
            return hp_t'(hp - dmg);
        end
        return '0;
    endfunction

    function automatic hp_t dmg_for(fighter_t f, option_e s);
        case (s)
            opt1:    return f.dmg1;
            opt2:    return f.dmg2;
            opt3:    return f.dmg3;
            default: return '0;
        endcase
    endfunction

    // 2x2 grid, index = row * 2 + col, only lone arrow keys move
    function automatic option_e grid_next(option_e cur, buttons_t k);
        int row;
        int col;
        row = int'(cur) / 2;
        col = int'(cur) % 2;
        if (k == key_up) begin
            row = 0;
        end else if (k == key_down) begin
            row = 1;
        end else if (k == key_left) begin
            col = 0;
        end else if (k == key_right) begin
            col = 1;
        end
        return option_e'(row * 2 + col);
    endfunction

    // walk through the grid, edge moves and one double press included
    function automatic buttons_t walk_key(int i);
        case (i)
            0, 1, 9: return key_right;
            2, 3, 10: return key_down;
            4, 5:    return key_left;
            6, 7:    return key_up;
            default: return key_right | key_down;
        endcase
    endfunction

    //////////////////////////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////////////////////////

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic compare(input string name, input logic [31:0] got,
                           input logic [31:0] want);
        if (got !== want) begin
            fail_run($sformatf("error at %0d ns: %s is %0d, expected %0d",
                               $time, name, got, want));
        end
    endtask

    // inputs change 2 ns after the rising edge
    task automatic step();
        @(posedge clk);
        #2;
    endtask

    task automatic press(input buttons_t k);
        keys = k;
        step();
        keys = '0;
    endtask

    task automatic do_load();
        load = 1'b1;
        step();
        load = 1'b0;
    endtask

    task automatic wait_state(input fight_state_e s, input string what);
        int n;
        n = 0;
        while (fight_state !== s) begin
            if (n == timeout_cycles) begin
                fail_run($sformatf("timeout: the %s state never arrived", what));
            end
            step();
            n++;
        end
    endtask

    task automatic wait_end();
        int n;
        n = 0;
        while (end_scene !== 1'b1) begin
            if (n == timeout_cycles) begin
                fail_run("timeout: end_scene never pulsed after the win state");
            end
            step();
            n++;
        end
    endtask

    // small stats so a normal round never knocks anyone out
    task automatic roll_fighters();
        p1.hp    = 40 + ($random(seed) & 15);
        p1.speed = $random(seed) & 15;
        p1.dmg1  = 1 + ($random(seed) & 3);
        p1.dmg2  = 1 + ($random(seed) & 3);
        p1.dmg3  = 1 + ($random(seed) & 3);
        p2.hp    = 40 + ($random(seed) & 15);
        p2.speed = $random(seed) & 15;
        p2.dmg1  = 1 + ($random(seed) & 3);
        p2.dmg2  = 1 + ($random(seed) & 3);
        p2.dmg3  = 1 + ($random(seed) & 3);
    endtask

    // one round from the menu back to the menu with skill s
    task automatic play_round(input option_e s);
        fight_state_e first;
        fight_state_e second;
        fight_state_e first_drain;
        int n;
        first       = (p1.speed >= p2.speed) ? attack_p1 : attack_p2;
        second      = (first == attack_p1) ? attack_p2 : attack_p1;
        first_drain = (first == attack_p1) ? drain_p2 : drain_p1;
        press(key_confirm);
        compare("fight_state", fight_state, choosing_skill);
        if (s == opt2) begin
            press(key_right);
        end
        if (s == opt3) begin
            press(key_down);
        end
        compare("option", option, s);
        press(key_confirm);
        compare("fight_state", fight_state, first);
        n = 0;
        while (fight_state === first && n < timeout_cycles) begin
            n++;
            step();
        end
        compare("animation cycles", n, `BATTLE_ANIM_TICKS);
        compare("fight_state", fight_state, first_drain);
        wait_state(second, "second attack");
        wait_state(menu, "menu");
        exp_p1 = expect_hp(p1.hp, dmg_for(p2, s));
        exp_p2 = expect_hp(p2.hp, dmg_for(p1, s));
        -> round_done;
    endtask

    // hit points checked once a round is over
    always @(round_done) begin
        compare("p1_hp", p1_hp, exp_p1);
        compare("p2_hp", p2_hp, exp_p2);
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////

    initial begin
        seed  = 32'h4ae6_125f;
        reset = 1'b1;
        load  = 1'b0;
        keys  = '0;
        p1    = '0;
        p2    = '0;
        repeat (3) @(posedge clk);
        #2;
        reset = 1'b0;
        compare("fight_state", fight_state, menu);
        compare("option", option, opt1);
        compare("p1_hp", p1_hp, 0);
        compare("p2_hp", p2_hp, 0);
        compare("end_scene", end_scene, 0);

        // cursor navigation
        roll_fighters();
        do_load();
        compare("p1_hp", p1_hp, p1.hp);
        compare("p2_hp", p2_hp, p2.hp);
        press(key_confirm);
        compare("fight_state", fight_state, choosing_skill);
        compare("option", option, opt1);
        exp_opt = opt1;
        for (int i = 0; i < 11; i++) begin
            press(walk_key(i));
            exp_opt = grid_next(exp_opt, walk_key(i));
            compare("option", option, exp_opt);
        end
        compare("option", option, opt4);
        press(key_confirm);
        compare("fight_state", fight_state, menu);
        compare("option", option, opt1);

        // run away, then the timed ending strobe
        press(key_right);
        compare("option", option, opt2);
        press(key_confirm);
        compare("fight_state", fight_state, p2_win);
        for (int i = 1; i <= `BATTLE_END_TICKS; i++) begin
            step();
            compare("end_scene", end_scene, i == `BATTLE_END_TICKS);
        end
        step();
        compare("end_scene", end_scene, 0);
        compare("fight_state", fight_state, p2_win);

        // turn order and full rounds
        roll_fighters();
        p1.speed = 8'd12;
        p2.speed = 8'd5;
        do_load();
        play_round(opt1);
        roll_fighters();
        p1.speed = 8'd2;
        p2.speed = 8'd11;
        do_load();
        play_round(opt2);
        roll_fighters();
        p2.speed = p1.speed;
        do_load();
        play_round(opt3);

        // knockout by the faster fighter, cursor left away from opt1
        roll_fighters();
        p1.speed = 8'd9;
        p2.speed = 8'd3;
        p1.dmg2  = p2.hp + ($random(seed) & 7);
        do_load();
        press(key_confirm);
        press(key_right);
        compare("option", option, opt2);
        press(key_confirm);
        compare("fight_state", fight_state, attack_p1);
        wait_state(p1_win, "p1_win");
        compare("p2_hp", p2_hp, expect_hp(p2.hp, p1.dmg2));
        compare("p1_hp", p1_hp, p1.hp);
        wait_end();
        step();
        compare("end_scene", end_scene, 0);

        // reload out of the win state
        roll_fighters();
        do_load();
        compare("fight_state", fight_state, menu);
        compare("option", option, opt1);
        compare("p1_hp", p1_hp, p1.hp);
        compare("p2_hp", p2_hp, p2.hp);
        compare("end_scene", end_scene, 0);

        $display("All tests passed");
        $finish;
    end

endmodule

//--- battle_ctrl.f
+incdir+logic
logic/battle_pkg.sv
logic/tick_timer.sv
logic/option_cursor.sv
logic/hp_drain.sv
logic/battle_fsm.sv
logic/battle_top.sv
tests/battle_tb.sv

//--- Bender.yml
package:
  name: battle_ctrl

sources:
  - include_dirs:
      - logic
    files:
      - logic/battle_pkg.sv
      - logic/tick_timer.sv
      - logic/option_cursor.sv
      - logic/hp_drain.sv
      - logic/battle_fsm.sv
      - logic/battle_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - tests/battle_tb.sv
